/* filelist.f */
logic/axil_pkg.sv
logic/monitor_pkg.sv
logic/axil_skid.sv
logic/axil_rd_path.sv
logic/rd_txn_tracker.sv
logic/monbus_filter.sv
logic/axil_rd_mon_top.sv
verif/tb_axil_rd_mon.sv

/* Bender.yml */
package:
  name: axil_rd_mon

sources:
  # Packages first
  - logic/axil_pkg.sv
  - logic/monitor_pkg.sv
  # RTL
  - logic/axil_skid.sv
  - logic/axil_rd_path.sv
  - logic/rd_txn_tracker.sv
  - logic/monbus_filter.sv
  - logic/axil_rd_mon_top.sv
  # Testbench
  - target: simulation
    files:
      - verif/tb_axil_rd_mon.sv

/* verif/tb_axil_rd_mon.sv */
// Testbench for the AXI4-Lite read master with transaction monitor
// Plays the fub master, an in-order AXI4-Lite slave and the monitor
// bus sink, and runs directed tests against the DUT
`timescale 1ns/1ps

module tb_axil_rd_mon;
    import axil_pkg::*;
    import monitor_pkg::*;

    localparam logic [3:0] UNIT_ID    = 4'd3;
    localparam logic [7:0] AGENT_ID   = 8'h42;
    localparam int         WAIT_LIMIT = 400;    // Cycles per wait loop

    logic        aclk;
    logic        rst_n;
    axil_ar_t    fub_ar;
    logic        fub_arvalid;
    logic        fub_arready;
    axil_r_t     fub_r;
    logic        fub_rvalid;
    logic        fub_rready;
    axil_ar_t    m_ar;
    logic        m_arvalid;
    logic        m_arready;
    axil_r_t     m_r;
    logic        m_rvalid;
    logic        m_rready;
    logic        cfg_monitor_enable;
    logic        cfg_error_enable;
    logic        cfg_timeout_enable;
    logic [15:0] cfg_timeout_cycles;
    logic [11:0] cfg_latency_threshold;
    logic [3:0]  cfg_pkt_mask;
    logic        monbus_valid;
    logic        monbus_ready;
    mon_pkt_t    monbus_packet;
    logic        busy;
    logic [7:0]  active_transactions;
    logic [31:0] transaction_count;
    logic [15:0] error_count;
    logic [7:0]  drop_count;

    // Slave model settings, changed per test
    int          slv_delay;
    axil_resp_e  slv_resp;
    logic        slv_hold;                     // Withhold all R beats

    logic [31:0] slv_pending [$];              // Addresses awaiting R
    axil_ar_t    ar_log [$];                   // Master ARs seen
    axil_r_t     r_log [$];                    // fub responses seen
    mon_pkt_t    pkt_log [$];                  // Monitor packets seen
    logic [31:0] sent_addr [$];
    logic [2:0]  sent_prot [$];

    int          errors;
    int          timeouts;

    axil_rd_mon_top #(
        .UNIT_ID  (UNIT_ID),
        .AGENT_ID (AGENT_ID),
        .MAX_TXN  (4),
        .AW       (32),
        .DW       (32)
    ) axil_rd_mon_top_inst (.*);

    // --------------------
    // Clock and helpers
    // --------------------
    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;              // 40 ns period
    end

    // Drive point, just after the rising edge
    task automatic step();
        @(posedge aclk);
        #2;
    endtask

    task automatic steps(input int n);
        repeat (n) step();
    endtask

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp,
                             input string msg);
        if (got !== exp) begin
            $display("Error at %0t ns: %s (got 0x%0h, expected 0x%0h)",
                     $time, msg, got, exp);
            errors++;
        end
    endtask

    // Slave read data, fixed per address
    function automatic logic [31:0] slave_data(input logic [31:0] addr);
        return {addr[15:0] ^ 16'h5A5A, addr[31:16]};
    endfunction

    task automatic clear_logs();
        ar_log.delete();
        r_log.delete();
        pkt_log.delete();
        sent_addr.delete();
        sent_prot.delete();
    endtask

    task automatic set_defaults();
        cfg_monitor_enable    = 1'b1;
        cfg_error_enable      = 1'b1;
        cfg_timeout_enable    = 1'b1;
        cfg_timeout_cycles    = 16'd200;
        cfg_latency_threshold = 12'd100;       // Out of reach normally
        cfg_pkt_mask          = 4'b0000;
        monbus_ready          = 1'b1;
        fub_rready            = 1'b1;
        slv_delay             = 2;
        slv_resp              = RESP_OKAY;
        slv_hold              = 1'b0;
    endtask

    // --------------------
    // Observers and slave
    // --------------------
    // Handshakes sampled mid-cycle, they complete on the next edge
    always @(negedge aclk) begin
        if (rst_n && m_arvalid && m_arready) begin
            slv_pending.push_back(m_ar.addr);
            ar_log.push_back(m_ar);
        end
        if (rst_n && fub_rvalid && fub_rready) r_log.push_back(fub_r);
        if (rst_n && monbus_valid && monbus_ready) pkt_log.push_back(monbus_packet);
    end

    // In-order R responder
    initial begin : slave_r
        logic [31:0] addr;
        int          cnt;
        m_rvalid = 1'b0;
        m_r      = '0;
        forever begin
            step();
            if (rst_n && !slv_hold && slv_pending.size() > 0) begin
                addr = slv_pending.pop_front();
                steps(slv_delay);
                m_r.data = slave_data(addr);
                m_r.resp = slv_resp;
                m_rvalid = 1'b1;
                cnt      = 0;
                @(negedge aclk);
                while (!m_rready && cnt < WAIT_LIMIT) begin
                    @(negedge aclk);
                    cnt++;
                end
                if (!m_rready) begin
                    $display("Timeout: the DUT never took the R beat for 0x%08h", addr);
                    timeouts++;
                end
                step();
                m_rvalid = 1'b0;
            end
        end
    end

    // --------------------
    // fub driver and waits
    // --------------------
    task automatic issue_read(input logic [31:0] addr, input logic [2:0] prot);
        int cnt;
        cnt         = 0;
        fub_ar.addr = addr;
        fub_ar.prot = prot;
        fub_arvalid = 1'b1;
        sent_addr.push_back(addr);
        sent_prot.push_back(prot);
        @(negedge aclk);
        while (!fub_arready && cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            cnt++;
        end
        if (!fub_arready) begin
            $display("Timeout: the read of 0x%08h was never accepted", addr);
            timeouts++;
        end
        step();
        fub_arvalid = 1'b0;
    endtask

    task automatic random_read();
        issue_read($urandom() & 32'hFFFF_FFFC, 3'($urandom_range(0, 7)));
    endtask

    task automatic wait_resps(input int n);
        int cnt;
        cnt = 0;
        while (r_log.size() < n && cnt < WAIT_LIMIT) begin
            step();
            cnt++;
        end
        if (r_log.size() < n) begin
            $display("Timeout: only %0d of %0d read responses came back", r_log.size(), n);
            timeouts++;
        end
    endtask

    task automatic wait_pkts(input int n);
        int cnt;
        cnt = 0;
        while (pkt_log.size() < n && cnt < WAIT_LIMIT) begin
            step();
            cnt++;
        end
        if (pkt_log.size() < n) begin
            $display("Timeout: only %0d of %0d monitor packets arrived", pkt_log.size(), n);
            timeouts++;
        end
    endtask

    // Type, code, IDs and address of one packet
    task automatic check_pkt(input int idx, input mon_pkt_type_e ptype,
                             input logic [3:0] code, input logic [31:0] addr);
        mon_pkt_t p;
        check_val(64'(idx < pkt_log.size()), 64'd1, $sformatf("packet %0d present", idx));
        if (idx < pkt_log.size()) begin
            p = pkt_log[idx];
            check_val(64'(p.pkt_type), 64'(ptype), "packet type");
            check_val(64'(p.event_code), 64'(code), "packet event code");
            check_val(64'(p.unit_id), 64'(UNIT_ID), "packet unit id");
            check_val(64'(p.agent_id), 64'(AGENT_ID), "packet agent id");
            check_val(64'(p.addr), 64'(addr), "packet address");
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_pass_through();
        clear_logs();
        fub_rready = 1'b0;                     // Stall the fub R side first
        fork
            repeat (6) random_read();
            begin
                steps(30);
                fub_rready = 1'b1;
            end
        join
        wait_resps(6);
        steps(10);
        check_val(ar_log.size(), 6, "master AR count");
        for (int i = 0; i < 6 && i < ar_log.size() && i < r_log.size(); i++) begin
            check_val(ar_log[i].addr, sent_addr[i], "master AR address");
            check_val(ar_log[i].prot, sent_prot[i], "master AR prot");
            check_val(r_log[i].data, slave_data(sent_addr[i]), "fub R data");
            check_val(r_log[i].resp, RESP_OKAY, "fub R resp");
        end
        check_val(pkt_log.size(), 6, "completion packet count");
    endtask

    task automatic test_completion();
        int tc0;
        tc0 = transaction_count;
        for (int i = 0; i < 4; i++) begin
            clear_logs();
            slv_delay = $urandom_range(0, 6);
            random_read();
            wait_pkts(1);
            wait_resps(1);
            check_pkt(0, PKT_COMPL, 4'd0, sent_addr[0]);
            if (pkt_log.size() > 0) begin
                check_val(pkt_log[0].latency >= slv_delay &&
                          pkt_log[0].latency <= slv_delay + 2, 1, "latency range");
            end
        end
        check_val(transaction_count, tc0 + 4, "transaction count");
        slv_delay = 2;
    endtask

    task automatic test_errors();
        int ec0;
        ec0      = error_count;
        slv_resp = RESP_SLVERR;
        clear_logs();
        random_read();
        wait_pkts(1);
        wait_resps(1);
        check_pkt(0, PKT_ERROR, 4'(RESP_SLVERR), sent_addr[0]);
        if (r_log.size() > 0) check_val(r_log[0].resp, RESP_SLVERR, "fub R resp");
        check_val(error_count, ec0 + 1, "error count");
        // Error packets off, reported as completion
        cfg_error_enable = 1'b0;
        clear_logs();
        random_read();
        wait_pkts(1);
        wait_resps(1);
        check_pkt(0, PKT_COMPL, 4'd0, sent_addr[0]);
        check_val(error_count, ec0 + 2, "error count with reporting off");
        cfg_error_enable = 1'b1;
        slv_resp         = RESP_OKAY;
    endtask

    task automatic test_timeout();
        int n_timeout;
        cfg_timeout_cycles    = 16'd20;
        cfg_latency_threshold = 12'd25;
        slv_delay             = 30;            // Timeout limit plus 10
        clear_logs();
        random_read();
        wait_pkts(3);
        steps(10);
        check_val(pkt_log.size(), 3, "packet count with timeout");
        check_pkt(0, PKT_TIMEOUT, 4'd0, sent_addr[0]);
        check_pkt(1, PKT_COMPL, 4'd0, sent_addr[0]);
        check_pkt(2, PKT_THRESH, 4'd0, sent_addr[0]);
        if (pkt_log.size() == 3) begin
            check_val(pkt_log[1].latency >= slv_delay &&
                      pkt_log[1].latency <= slv_delay + 2, 1, "completion latency range");
            check_val(pkt_log[2].latency >= slv_delay &&
                      pkt_log[2].latency <= slv_delay + 2, 1, "threshold latency range");
        end
        // Same read with timeouts disabled
        cfg_timeout_enable = 1'b0;
        clear_logs();
        random_read();
        wait_pkts(2);
        steps(10);
        n_timeout = 0;
        foreach (pkt_log[i]) if (pkt_log[i].pkt_type == PKT_TIMEOUT) n_timeout++;
        check_val(n_timeout, 0, "timeout packets while disabled");
        check_val(pkt_log.size(), 2, "packet count without timeout");
        set_defaults();
    endtask

    task automatic test_mask_backpressure();
        int tc0;
        int dc0;
        tc0          = transaction_count;
        cfg_pkt_mask = 4'b0100;                // Drop completions
        clear_logs();
        repeat (3) random_read();
        wait_resps(3);
        steps(10);
        check_val(pkt_log.size(), 0, "packets with completion masked");
        check_val(transaction_count, tc0 + 3, "count under mask");
        cfg_pkt_mask = 4'b0000;
        // Sink stalled over six error reads
        dc0          = drop_count;
        monbus_ready = 1'b0;
        slv_resp     = RESP_SLVERR;
        clear_logs();
        repeat (6) random_read();
        wait_resps(6);
        steps(5);
        check_val(pkt_log.size(), 0, "packets while sink stalled");
        check_val(drop_count, dc0 + 2, "drop count");
        monbus_ready = 1'b1;
        wait_pkts(4);
        steps(10);
        check_val(pkt_log.size(), 4, "queued packet count");
        for (int i = 0; i < 4; i++) check_pkt(i, PKT_ERROR, 4'(RESP_SLVERR), sent_addr[i]);
        slv_resp = RESP_OKAY;
    endtask

    task automatic test_outstanding_limit();
        clear_logs();
        slv_hold = 1'b1;
        fork
            repeat (5) random_read();
            begin
                steps(20);
                check_val(ar_log.size(), 4, "master ARs with slave silent");
                check_val(active_transactions, 4, "active transactions");
                check_val(busy, 1, "busy while full");
                slv_hold = 1'b0;
            end
        join
        wait_resps(5);
        steps(5);
        check_val(ar_log.size(), 5, "master ARs after release");
        if (ar_log.size() == 5) check_val(ar_log[4].addr, sent_addr[4], "fifth AR address");
        check_val(active_transactions, 0, "active transactions at end");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(17720));
        errors      = 0;
        timeouts    = 0;
        rst_n       = 1'b0;
        fub_ar      = '0;
        fub_arvalid = 1'b0;
        m_arready   = 1'b1;                    // Slave always takes AR
        set_defaults();
        steps(10);
        rst_n = 1'b1;
        steps(2);
        check_val(m_rready, 1, "m_rready after reset");
        check_val(transaction_count, 0, "transaction count after reset");

        test_pass_through();
        test_completion();
        test_errors();
        test_timeout();
        test_mask_backpressure();
        test_outstanding_limit();

        $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_axil_rd_mon

/* logic/axil_rd_mon_top.sv */
// AXI4-Lite read master with transaction monitor
// Read path skid buffers, outstanding-read tracker and monitor bus
// packet filter
`timescale 1ns/1ps

module axil_rd_mon_top #(
    parameter logic [3:0] UNIT_ID  = 4'd1,
    parameter logic [7:0] AGENT_ID = 8'd10,
    parameter int         MAX_TXN  = 4,
    parameter int         AW       = axil_pkg::AXIL_AW,
    parameter int         DW       = axil_pkg::AXIL_DW
) (
    input  logic                  aclk,
    input  logic                  rst_n,
    // fub AR / R
    input  axil_pkg::axil_ar_t    fub_ar,
    input  logic                  fub_arvalid,
    output logic                  fub_arready,
    output axil_pkg::axil_r_t     fub_r,
    output logic                  fub_rvalid,
    input  logic                  fub_rready,
    // Master AR / R
    output axil_pkg::axil_ar_t    m_ar,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  axil_pkg::axil_r_t     m_r,
    input  logic                  m_rvalid,
    output logic                  m_rready,
    // Configuration
    input  logic                  cfg_monitor_enable,
    input  logic                  cfg_error_enable,
    input  logic                  cfg_timeout_enable,
    input  logic [15:0]           cfg_timeout_cycles,
    input  logic [11:0]           cfg_latency_threshold,
    input  logic [3:0]            cfg_pkt_mask,
    // Monitor bus
    output logic                  monbus_valid,
    input  logic                  monbus_ready,
    output monitor_pkg::mon_pkt_t monbus_packet,
    // Status
    output logic                  busy,
    output logic [7:0]            active_transactions,
    output logic [31:0]           transaction_count,
    output logic [15:0]           error_count,
    output logic [7:0]            drop_count
);
    import monitor_pkg::*;

    logic       ar_allow;
    logic       m_ar_fire;
    logic       m_r_fire;
    mon_event_t evt;
    logic       evt_valid;

    assign m_ar_fire = m_arvalid & m_arready;
    assign m_r_fire  = m_rvalid & m_rready;

    // --------------------
    // Read path
    // --------------------
    axil_rd_path #(.AW(AW), .DW(DW)) axil_rd_path_inst (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .fub_ar      (fub_ar),
        .fub_arvalid (fub_arvalid),
        .fub_arready (fub_arready),
        .fub_r       (fub_r),
        .fub_rvalid  (fub_rvalid),
        .fub_rready  (fub_rready),
        .m_ar        (m_ar),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .m_r         (m_r),
        .m_rvalid    (m_rvalid),
        .m_rready    (m_rready),
        .ar_allow    (ar_allow),
        .busy        (busy)
    );

    // Watches master-side handshakes
    rd_txn_tracker #(.MAX_TXN(MAX_TXN)) rd_txn_tracker_inst (
        .aclk                  (aclk),
        .rst_n                 (rst_n),
        .m_ar                  (m_ar),
        .m_ar_fire             (m_ar_fire),
        .m_r                   (m_r),
        .m_r_fire              (m_r_fire),
        .timeout_enable        (cfg_timeout_enable),
        .error_enable          (cfg_error_enable),
        .cfg_timeout_cycles    (cfg_timeout_cycles),
        .cfg_latency_threshold (cfg_latency_threshold),
        .ar_allow              (ar_allow),
        .evt                   (evt),
        .evt_valid             (evt_valid),
        .active_transactions   (active_transactions),
        .transaction_count     (transaction_count),
        .error_count           (error_count)
    );

    // --------------------
    // Monitor output
    // --------------------
    monbus_filter #(.UNIT_ID(UNIT_ID), .AGENT_ID(AGENT_ID)) monbus_filter_inst (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .evt            (evt),
        .evt_valid      (evt_valid),
        .monitor_enable (cfg_monitor_enable),
        .cfg_pkt_mask   (cfg_pkt_mask),
        .monbus_valid   (monbus_valid),
        .monbus_ready   (monbus_ready),
        .monbus_packet  (monbus_packet),
        .drop_count     (drop_count)
    );

endmodule : axil_rd_mon_top

/* logic/monbus_filter.sv */
// Monitor bus packet filter and queue
// Drops events by per-type mask, adds unit and agent IDs and queues
// packets four deep for a valid/ready monitor bus
`timescale 1ns/1ps

module monbus_filter #(
    parameter logic [3:0] UNIT_ID  = 4'd1,
    parameter logic [7:0] AGENT_ID = 8'd10
) (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  monitor_pkg::mon_event_t evt,
    input  logic                    evt_valid,
    input  logic                    monitor_enable,
    input  logic [3:0]              cfg_pkt_mask,   // 1 drops that type
    output logic                    monbus_valid,
    input  logic                    monbus_ready,
    output monitor_pkg::mon_pkt_t   monbus_packet,
    output logic [7:0]              drop_count
);
    import monitor_pkg::*;

    mon_pkt_t   queue [4];                 // Packet storage
    mon_pkt_t   pkt_in;
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] count;
    logic       keep;                      // Passes enable and mask
    logic       push;
    logic       pop;

    assign keep = evt_valid & monitor_enable & ~cfg_pkt_mask[evt.pkt_type[1:0]];
    assign push = keep & (count != 3'd4);
    assign pop  = monbus_valid & monbus_ready;

    // Stamp IDs into the event
    always_comb begin
        pkt_in.pkt_type   = evt.pkt_type;
        pkt_in.event_code = evt.event_code;
        pkt_in.unit_id    = UNIT_ID;
        pkt_in.agent_id   = AGENT_ID;
        pkt_in.latency    = evt.latency;
        pkt_in.addr       = evt.addr;
    end

    // --------------------
    // Queue control
    // --------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr     <= 2'd0;
            rd_ptr     <= 2'd0;
            count      <= 3'd0;
            drop_count <= 8'd0;
        end else begin
            count <= count + {2'b00, push} - {2'b00, pop};
            if (push) wr_ptr <= wr_ptr + 2'd1;
            if (pop)  rd_ptr <= rd_ptr + 2'd1;
            if (keep && !push) drop_count <= drop_count + 8'd1;  // Full
        end
    end

    always_ff @(posedge aclk) begin
        if (push) queue[wr_ptr] <= pkt_in;
    end

    assign monbus_valid  = (count != 3'd0);
    assign monbus_packet = queue[rd_ptr];

endmodule : monbus_filter

/* logic/rd_txn_tracker.sv */
// Outstanding read tracker
// In-order table of issued reads (AXI4-Lite has no IDs), latency and
// timeout timing, monitor event generation and read/error counters
`timescale 1ns/1ps

module rd_txn_tracker #(
    parameter int MAX_TXN = 4              // Power of two, 2 or more
) (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  axil_pkg::axil_ar_t      m_ar,
    input  logic                    m_ar_fire,
    input  axil_pkg::axil_r_t       m_r,
    input  logic                    m_r_fire,
    input  logic                    timeout_enable,
    input  logic                    error_enable,
    input  logic [15:0]             cfg_timeout_cycles,
    input  logic [11:0]             cfg_latency_threshold,
    output logic                    ar_allow,
    output monitor_pkg::mon_event_t evt,
    output logic                    evt_valid,
    output logic [7:0]              active_transactions,
    output logic [31:0]             transaction_count,
    output logic [15:0]             error_count
);
    import axil_pkg::*;
    import monitor_pkg::*;

    localparam int PW = $clog2(MAX_TXN);
    localparam int CW = PW + 1;

    logic [31:0]        addr_tbl  [MAX_TXN];
    logic [15:0]        start_tbl [MAX_TXN];   // Cycle stamp at AR
    logic [MAX_TXN-1:0] timed_out;             // Timeout already sent
    logic [PW-1:0]      wr_ptr;
    logic [PW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic [CW-1:0]      count_next;
    logic [15:0]        stamp;                 // Free-running
    logic [15:0]        age;                   // Oldest entry
    logic [11:0]        lat_sat;
    logic               is_err;
    logic               timeout_hit;
    mon_event_t         thr_evt;               // Staged threshold
    logic               thr_valid;
    mon_event_t         hold_evt;              // Deferred threshold
    logic               hold_valid;
    logic               emit_thr;
    logic               emit_hold;

    assign count_next = count + CW'(m_ar_fire) - CW'(m_r_fire);
    assign active_transactions = 8'(count);

    assign age     = stamp - start_tbl[rd_ptr];    // Wraps cleanly
    assign lat_sat = (age > 16'(LAT_MAX)) ? LAT_MAX : age[11:0];
    assign is_err  = (m_r.resp == RESP_SLVERR) || (m_r.resp == RESP_DECERR);

    // First cycle past the limit, not on the popping cycle
    assign timeout_hit = timeout_enable && (count != '0) && !timed_out[rd_ptr]
                         && !m_r_fire && (age > cfg_timeout_cycles);

    // --------------------
    // Event select
    // --------------------
    // R pop > timeout > held threshold > fresh threshold
    always_comb begin
        evt       = thr_evt;
        evt_valid = 1'b0;
        emit_thr  = 1'b0;
        emit_hold = 1'b0;
        if (m_r_fire) begin
            evt_valid      = 1'b1;
            evt.pkt_type   = (is_err && error_enable) ? PKT_ERROR : PKT_COMPL;
            evt.event_code = (is_err && error_enable) ? {2'b00, m_r.resp} : 4'd0;
            evt.latency    = lat_sat;
            evt.addr       = addr_tbl[rd_ptr];
        end else if (timeout_hit) begin
            evt_valid      = 1'b1;
            evt.pkt_type   = PKT_TIMEOUT;
            evt.event_code = 4'd0;
            evt.latency    = lat_sat;
            evt.addr       = addr_tbl[rd_ptr];
        end else if (hold_valid) begin
            evt       = hold_evt;
            evt_valid = 1'b1;
            emit_hold = 1'b1;
        end else if (thr_valid) begin
            evt_valid = 1'b1;                  // evt already thr_evt
            emit_thr  = 1'b1;
        end
    end

    // --------------------
    // Table and control
    // --------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            count             <= '0;
            wr_ptr            <= '0;
            rd_ptr            <= '0;
            timed_out         <= '0;
            stamp             <= 16'd0;
            ar_allow          <= 1'b0;         // Opens the cycle after reset
            thr_valid         <= 1'b0;
            hold_valid        <= 1'b0;
            transaction_count <= 32'd0;
            error_count       <= 16'd0;
        end else begin
            stamp    <= stamp + 16'd1;
            count    <= count_next;
            ar_allow <= (count_next < CW'(MAX_TXN));
            if (timeout_hit) timed_out[rd_ptr] <= 1'b1;
            if (m_ar_fire) begin
                timed_out[wr_ptr] <= 1'b0;     // Fresh entry
                wr_ptr            <= wr_ptr + 1'b1;
            end
            if (m_r_fire) begin
                rd_ptr            <= rd_ptr + 1'b1;
                transaction_count <= transaction_count + 32'd1;
                if (is_err) error_count <= error_count + 16'd1;
            end
            thr_valid <= m_r_fire && (lat_sat > cfg_latency_threshold);
            if (emit_hold) hold_valid <= 1'b0;
            if (thr_valid && !emit_thr) hold_valid <= 1'b1;  // Lost slot, defer
        end
    end

    // Payload registers
    always_ff @(posedge aclk) begin
        if (m_ar_fire) begin
            addr_tbl[wr_ptr]  <= m_ar.addr;
            start_tbl[wr_ptr] <= stamp;
        end
        if (m_r_fire) begin
            thr_evt <= '{pkt_type: PKT_THRESH, event_code: 4'd0,
                         latency: lat_sat, addr: addr_tbl[rd_ptr]};
        end
        if (thr_valid && !emit_thr) hold_evt <= thr_evt;
    end

endmodule : rd_txn_tracker

/* logic/axil_rd_path.sv */
// AXI4-Lite read data path
// Skid buffers on AR (fub to master) and R (master to fub), with AR
// admission held off by the tracker when the read table is full
`timescale 1ns/1ps

module axil_rd_path #(
    parameter int AW = axil_pkg::AXIL_AW,
    parameter int DW = axil_pkg::AXIL_DW
) (
    input  logic               aclk,
    input  logic               rst_n,
    // fub side
    input  axil_pkg::axil_ar_t fub_ar,
    input  logic               fub_arvalid,
    output logic               fub_arready,
    output axil_pkg::axil_r_t  fub_r,
    output logic               fub_rvalid,
    input  logic               fub_rready,
    // Master side
    output axil_pkg::axil_ar_t m_ar,
    output logic               m_arvalid,
    input  logic               m_arready,
    input  axil_pkg::axil_r_t  m_r,
    input  logic               m_rvalid,
    output logic               m_rready,
    // Status and admission
    input  logic               ar_allow,
    output logic               busy
);
    import axil_pkg::*;

    // Bits above the configured widths are forced low
    localparam logic [AXIL_AW-1:0] ADDR_MASK =
        (AW >= AXIL_AW) ? '1 : AXIL_AW'((64'd1 << AW) - 64'd1);
    localparam logic [AXIL_DW-1:0] DATA_MASK =
        (DW >= AXIL_DW) ? '1 : AXIL_DW'((64'd1 << DW) - 64'd1);

    axil_ar_t ar_q;                        // AR skid output
    logic     ar_in_ready;
    logic     ar_out_valid;
    axil_r_t  r_q;                         // R skid output

    // --------------------
    // AR channel
    // --------------------
    assign fub_arready = ar_in_ready & ar_allow;  // Both from flops
    assign m_arvalid   = ar_out_valid & ar_allow; // Table has room

    axil_skid #(.payload_t(axil_ar_t)) ar_skid_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (fub_ar),
        .in_valid  (fub_arvalid & ar_allow),
        .in_ready  (ar_in_ready),
        .out_data  (ar_q),
        .out_valid (ar_out_valid),
        .out_ready (m_arready & ar_allow)
    );

    always_comb begin
        m_ar      = ar_q;
        m_ar.addr = ar_q.addr & ADDR_MASK;
    end

    // --------------------
    // R channel
    // --------------------
    axil_skid #(.payload_t(axil_r_t)) r_skid_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (m_r),
        .in_valid  (m_rvalid),
        .in_ready  (m_rready),             // fub back-pressure shows here
        .out_data  (r_q),
        .out_valid (fub_rvalid),
        .out_ready (fub_rready)
    );

    always_comb begin
        fub_r      = r_q;
        fub_r.data = r_q.data & DATA_MASK;
    end

    // Anything held or waiting at the fub port
    assign busy = ar_out_valid | fub_rvalid | fub_arvalid;

endmodule : axil_rd_path

/* logic/axil_skid.sv */
// Two-entry registered skid buffer
// Holds up to two payloads so in_ready comes straight from a flop;
// sustains one transfer per cycle when the output is not stalled
`timescale 1ns/1ps

module axil_skid #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     aclk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t   slot [2];                  // Storage, no reset
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;                     // Entries held, 0..2
    logic [1:0] count_next;
    logic       push;
    logic       pop;

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    assign count_next = count + {1'b0, push} - {1'b0, pop};

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            count    <= 2'd0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            in_ready <= 1'b1;              // Empty buffer can take data
        end else begin
            count    <= count_next;
            in_ready <= (count_next != 2'd2);  // Registered ready
            if (push) wr_ptr <= ~wr_ptr;
            if (pop)  rd_ptr <= ~rd_ptr;
        end
    end

    // Payload write
    always_ff @(posedge aclk) begin
        if (push) slot[wr_ptr] <= in_data;
    end

    assign out_valid = (count != 2'd0);
    assign out_data  = slot[rd_ptr];       // Oldest entry

endmodule : axil_skid

/* logic/monitor_pkg.sv */
// Monitor bus definitions
// Packet types, the 64-bit packet layout and the event record passed
// from the transaction tracker to the packet filter
package monitor_pkg;

    // Packet type; value doubles as bit index into the drop mask
    typedef enum logic [3:0] {
        PKT_ERROR   = 4'd0,                // SLVERR or DECERR response
        PKT_TIMEOUT = 4'd1,                // Oldest read waited too long
        PKT_COMPL   = 4'd2,                // Normal completion
        PKT_THRESH  = 4'd3                 // Latency above threshold
    } mon_pkt_type_e;

    // --------------------
    // Monitor bus packet
    // --------------------
    // 64 bits, MSB first
    typedef struct packed {
        mon_pkt_type_e pkt_type;           // [63:60]
        logic [3:0]    event_code;         // [59:56] resp code for errors
        logic [3:0]    unit_id;            // [55:52]
        logic [7:0]    agent_id;           // [51:44]
        logic [11:0]   latency;            // [43:32] cycles, saturating
        logic [31:0]   addr;               // [31:0]
    } mon_pkt_t;

    // --------------------
    // Tracker event
    // --------------------
    // IDs get added later by the filter
    typedef struct packed {
        mon_pkt_type_e pkt_type;
        logic [3:0]    event_code;
        logic [11:0]   latency;
        logic [31:0]   addr;
    } mon_event_t;

    localparam logic [11:0] LAT_MAX = 12'hFFF;  // Saturation value

endpackage : monitor_pkg

/* logic/axil_pkg.sv */
// AXI4-Lite read channel definitions
// AR and R payload structs plus the response codes shared by the
// read path, the tracker and the top level
package axil_pkg;

    // --------------------
    // Default widths
    // --------------------
    localparam int AXIL_AW = 32;           // Address width default
    localparam int AXIL_DW = 32;           // Data width default

    // Response codes as carried on RRESP
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,               // Not expected from AXI4-Lite slaves
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_e;

    // --------------------
    // Channel payloads
    // --------------------
    // Read address channel
    typedef struct packed {
        logic [AXIL_AW-1:0] addr;          // ARADDR
        logic [2:0]         prot;          // ARPROT
    } axil_ar_t;

    // Read data channel
    typedef struct packed {
        logic [AXIL_DW-1:0] data;          // RDATA
        logic [1:0]         resp;          // RRESP, see axil_resp_e
    } axil_r_t;

endpackage : axil_pkg
